//--- Makefile
sim:
	verilator --binary --timing --top-module microSeqTb -f tb.f -Mdir obj_dir
	out=$$(./obj_dir/VmicroSeqTb); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- tb.f
verilog/microSeqPkg.sv
verilog/microSeqCrm.sv
verilog/sbrStack.sv
verilog/craDiag.sv
verilog/cra.sv
verilog/microSeq.sv
verif/microSeqTb.sv

//--- verif/microSeqTb.sv
`timescale 1ns/1ps

module microSeqTb;

  logic eboxClk;
  logic arstN;
  logic run;
  logic force1777;
  logic [microSeqPkg::dramAWidth-1:0] dramA;
  microSeqPkg::tAdr dramJ;
  logic [microSeqPkg::condInWidth-1:0] condIn;
  logic loadEn;
  microSeqPkg::tAdr loadAdr;
  microSeqPkg::tCram loadWord;
  microSeqPkg::tDiagSel diagSel;
  logic diagRead;
  logic diagLoadEn;
  microSeqPkg::tAdr diagLoadVal;
  microSeqPkg::tAdr cradr;
  microSeqPkg::tDiagBus diagBus;

  microSeq i_microSeq (
    .eboxClk     (eboxClk),
    .arstN       (arstN),
    .run         (run),
    .force1777   (force1777),
    .dramA       (dramA),
    .dramJ       (dramJ),
    .condIn      (condIn),
    .loadEn      (loadEn),
    .loadAdr     (loadAdr),
    .loadWord    (loadWord),
    .diagSel     (diagSel),
    .diagRead    (diagRead),
    .diagLoadEn  (diagLoadEn),
    .diagLoadVal (diagLoadVal),
    .cradr       (cradr),
    .diagBus     (diagBus)
  );

  always #10 eboxClk = ~eboxClk;

  // Model state, mirrors the sequencer registers
  microSeqPkg::tCram modelMem [microSeqPkg::cramWords];
  microSeqPkg::tAdr mStack [microSeqPkg::stackDepth];
  microSeqPkg::tCram mWord;
  microSeqPkg::tAdr mAread;
  microSeqPkg::tAdr mLoc;
  microSeqPkg::tAdr mRet;
  microSeqPkg::tAdr mDiag;
  microSeqPkg::tAdr expAdr;
  microSeqPkg::tDiagBus expDiag;
  logic [3:0] mSp;
  logic mPush;
  logic mPop;
  logic diagKnown;

  // Inputs seen at the last falling edge, applied at the next rising edge
  logic pRun;
  logic pForce;
  logic [microSeqPkg::dramAWidth-1:0] pDramA;
  microSeqPkg::tAdr pDramJ;
  microSeqPkg::tAdr pAdr;
  logic pDiagLoad;
  microSeqPkg::tAdr pDiagVal;

  logic [31:0] seed;
  string testName;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic microSeqPkg::tCram buildWord(
    input microSeqPkg::tAdr j,
    input microSeqPkg::tDisp disp,
    input microSeqPkg::tCond cond,
    input logic call
  );
    microSeqPkg::tCram w;
    w.j = j;
    w.disp = disp;
    w.cond = cond;
    w.call = call;
    return w;
  endfunction

  // Expected next address of the executing word
  function automatic microSeqPkg::tAdr nextAdr(
    input microSeqPkg::tCram w,
    input logic trap,
    input microSeqPkg::tAdr dj,
    input logic [microSeqPkg::condInWidth-1:0] ci,
    input microSeqPkg::tAdr ar,
    input microSeqPkg::tAdr dg,
    input microSeqPkg::tAdr ret
  );
    microSeqPkg::tAdr a;
    logic [3:0] off;
    logic [2:0] s;
    a = w.j;
    off = (w.cond == microSeqPkg::condNone) ? 4'd0 : w.cond - microSeqPkg::cond0;
    s = off[2:0];
    case (w.disp)
      microSeqPkg::dispDiag:   a = a | dg;
      microSeqPkg::dispDramJ:  a = a | dj;
      microSeqPkg::dispAread:  a = a | ar;
      microSeqPkg::dispReturn: a = a | ret;
      microSeqPkg::dispCond3: begin
        // Group wraps around the top of the condition vector
        a[8] = a[8] | ci[s];
        a[9] = a[9] | ci[s + 3'd1];
        a[10] = a[10] | ci[s + 3'd2];
      end
      default: a = a;
    endcase
    if (w.cond != microSeqPkg::condNone && w.disp != microSeqPkg::dispCond3 && ci[s]) begin
      a[0] = 1'b1;
    end
    if (trap) begin
      a = '1;
    end
    return a;
  endfunction

  task automatic checkAdr(input string name, input microSeqPkg::tAdr exp,
                          input microSeqPkg::tAdr act);
    if (exp !== act) begin
      $display("FAILED %s: cradr expected %h, actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkDiag(input string name, input microSeqPkg::tDiagBus exp,
                           input microSeqPkg::tDiagBus act);
    if (exp !== act) begin
      $display("FAILED %s: diagBus expected %h, actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  //////////////////////////////
  // Reference model and compare
  //////////////////////////////

  always @(negedge eboxClk) begin
    if (!arstN) begin
      mWord = '0;
      mAread = '0;
      mLoc = '0;
      mSp = '0;
      mDiag = '0;
      pRun = 1'b0;
      pDiagLoad = 1'b0;
    end else begin
      if (pRun) begin
        mPush = mWord.call | pForce;
        mPop = (mWord.disp == microSeqPkg::dispReturn) & ~pForce;
        if (!mPush && !mPop) begin
          mRet = mStack[mSp - 4'd1];
        end
        if (mPush && mPop) begin
          mSp = '0;
        end else if (mPush) begin
          mStack[mSp] = mLoc;
          mSp = mSp + 4'd1;
        end else if (mPop) begin
          mSp = mSp - 4'd1;
        end
        mAread = (pDramA == '0) ? pDramJ : '0;
        mLoc = pAdr;
        mWord = modelMem[pAdr];
      end
      if (pDiagLoad) begin
        mDiag = pDiagVal;
      end
      expAdr = nextAdr(mWord, force1777, dramJ, condIn, mAread, mDiag, mRet);
      checkAdr(testName, expAdr, cradr);

      diagKnown = 1'b1;
      expDiag.valid = diagRead;
      expDiag.data = '0;
      if (diagRead) begin
        case (diagSel)
          microSeqPkg::diagRet:     expDiag.data = mRet;
          microSeqPkg::diagAdr:     expDiag.data = expAdr;
          microSeqPkg::diagLoc:     expDiag.data = mLoc;
          microSeqPkg::diagDispAdr: expDiag.data = mDiag;
          default:                  diagKnown = 1'b0;
        endcase
      end
      if (diagKnown) begin
        checkDiag(testName, expDiag, diagBus);
      end

      pRun = run;
      pForce = force1777;
      pDramA = dramA;
      pDramJ = dramJ;
      pAdr = expAdr;
      pDiagLoad = diagLoadEn;
      pDiagVal = diagLoadVal;
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic resetDut();
    @(posedge eboxClk);
    run <= 1'b0;
    arstN <= 1'b0;
    repeat (8) @(posedge eboxClk);
    arstN <= 1'b1;
  endtask

  task automatic loadAt(input microSeqPkg::tAdr adr, input microSeqPkg::tCram w);
    @(posedge eboxClk);
    loadEn <= 1'b1;
    loadAdr <= adr;
    loadWord <= w;
    modelMem[adr] = w;
  endtask

  // Every word jumps back into the low 64 words
  task automatic fillMemory();
    microSeqPkg::tAdr adr;
    for (int a = 0; a < microSeqPkg::cramWords; a++) begin
      adr = 11'(a);
      loadAt(adr, buildWord((adr ^ (adr >> 5)) & 11'h03F, microSeqPkg::dispNone,
                            microSeqPkg::condNone, 1'b0));
    end
  endtask

  // Mode 0 plain jumps, 1 DRAM dispatch, 2 skips and condition group
  task automatic loadRegion(input int mode);
    logic [31:0] r;
    microSeqPkg::tDisp d;
    microSeqPkg::tCond c;
    for (int a = 0; a < 64; a++) begin
      r = nextRand();
      d = microSeqPkg::dispNone;
      c = microSeqPkg::condNone;
      if (mode == 1) begin
        case (r[25:24])
          2'd0:    d = microSeqPkg::dispDramJ;
          2'd1:    d = microSeqPkg::dispAread;
          default: d = microSeqPkg::dispNone;
        endcase
      end else if (mode == 2) begin
        d = r[25] ? microSeqPkg::dispCond3 : microSeqPkg::dispNone;
        if (r[20:19] != 2'd0) begin
          c = microSeqPkg::tCond'(microSeqPkg::cond0 + {1'b0, r[23:21]});
        end
      end
      loadAt(11'(a), buildWord({5'd0, r[31:26]}, d, c, 1'b0));
    end
  endtask

  task automatic runRandom(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++) begin
      r = nextRand();
      @(posedge eboxClk);
      run <= 1'b1;
      loadEn <= 1'b0;
      dramJ <= {5'd0, r[31:26]};
      dramA <= r[25] ? 3'd0 : r[24:22];
      condIn <= r[21:14];
    end
  endtask

  task automatic runUntil(input microSeqPkg::tAdr target, input int limit);
    int n;
    n = 0;
    @(posedge eboxClk);
    run <= 1'b1;
    loadEn <= 1'b0;
    @(negedge eboxClk);
    while (cradr !== target) begin
      if (n == limit) begin
        $display("Timeout in %s: cradr never reached %h in %0d cycles", testName, target,
                 limit);
        $display("TB FAILED");
        $fatal(1);
      end
      n++;
      @(negedge eboxClk);
    end
  endtask

  task automatic stopRun();
    @(posedge eboxClk);
    run <= 1'b0;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    microSeqPkg::tAdr diagTarget;
    logic [31:0] r;
    eboxClk = 1'b0;
    arstN = 1'b0;
    run = 1'b0;
    force1777 = 1'b0;
    dramA = '0;
    dramJ = '0;
    condIn = '0;
    loadEn = 1'b0;
    loadAdr = '0;
    loadWord = '0;
    diagSel = microSeqPkg::diagRet;
    diagRead = 1'b0;
    diagLoadEn = 1'b0;
    diagLoadVal = '0;
    seed = 32'd41643;
    mRet = '0;
    for (int i = 0; i < microSeqPkg::stackDepth; i++) begin
      mStack[i] = '0;
    end
    testName = "fill";
    resetDut();
    fillMemory();

    testName = "plainJumps";
    resetDut();
    loadRegion(0);
    runRandom(200);
    stopRun();

    testName = "dramDispatch";
    resetDut();
    loadRegion(1);
    runRandom(300);
    stopRun();

    testName = "skipCond3";
    resetDut();
    loadRegion(2);
    runRandom(300);
    stopRun();

    // Twenty nested calls, each return lands at 0x300 plus depth
    testName = "callReturn";
    resetDut();
    loadAt(11'h000, buildWord(11'h100, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    for (int k = 0; k < 20; k++) begin
      loadAt(11'h100 + 11'(k), buildWord((k < 19) ? 11'h101 + 11'(k) : 11'h140,
             microSeqPkg::dispNone, microSeqPkg::condNone, 1'b1));
      loadAt(11'h300 + 11'(k), buildWord(11'h180, microSeqPkg::dispNone,
             microSeqPkg::condNone, 1'b0));
    end
    loadAt(11'h140, buildWord(11'h180, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h180, buildWord(11'h200, microSeqPkg::dispReturn, microSeqPkg::condNone, 1'b0));
    runUntil(11'h304, 200);
    runRandom(12);
    stopRun();

    testName = "trap";
    resetDut();
    loadAt(11'h000, buildWord(11'h400, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h400, buildWord(11'h401, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h401, buildWord(11'h402, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h402, buildWord(11'h400, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h7FF, buildWord(11'h410, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h410, buildWord(11'h411, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h411, buildWord(11'h000, microSeqPkg::dispReturn, microSeqPkg::condNone, 1'b0));
    runUntil(11'h402, 20);
    @(posedge eboxClk);
    force1777 <= 1'b1;
    @(negedge eboxClk);
    checkAdr(testName, 11'h7FF, cradr);
    @(posedge eboxClk);
    force1777 <= 1'b0;
    runUntil(11'h402, 20);
    stopRun();

    testName = "diagnostics";
    resetDut();
    r = nextRand();
    diagTarget = {3'b101, r[31:24]};
    @(posedge eboxClk);
    diagLoadEn <= 1'b1;
    diagLoadVal <= diagTarget;
    @(posedge eboxClk);
    diagLoadEn <= 1'b0;
    loadAt(11'h000, buildWord(11'h420, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h420, buildWord(11'h000, microSeqPkg::dispDiag, microSeqPkg::condNone, 1'b0));
    loadAt(diagTarget, buildWord(11'h421, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h421, buildWord(11'h422, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b1));
    loadAt(11'h422, buildWord(11'h423, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    loadAt(11'h423, buildWord(11'h420, microSeqPkg::dispNone, microSeqPkg::condNone, 1'b0));
    runUntil(diagTarget, 20);
    for (int i = 0; i < 60; i++) begin
      r = nextRand();
      @(posedge eboxClk);
      diagRead <= r[31];
      // Selects diagRet through diagDispAdr
      diagSel <= microSeqPkg::tDiagSel'({1'b0, r[30:29]} + 3'd1);
    end
    @(posedge eboxClk);
    diagRead <= 1'b0;
    stopRun();
    repeat (2) @(posedge eboxClk);

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- verilog/cra.sv
`timescale 1ns/1ps

module cra (
  input  logic                                 eboxClk,
  input  logic                                 arstN,
  input  logic                                 run,
  input  logic                                 force1777,
  input  microSeqPkg::tCram                    cramWord,
  input  logic [microSeqPkg::dramAWidth-1:0]   dramA,
  input  microSeqPkg::tAdr                     dramJ,
  input  logic [microSeqPkg::condInWidth-1:0]  condIn,
  input  microSeqPkg::tDiagSel                 diagSel,
  input  logic                                 diagRead,
  input  logic                                 diagLoadEn,
  input  microSeqPkg::tAdr                     diagLoadVal,
  output microSeqPkg::tAdr                     cradr,
  output microSeqPkg::tDiagBus                 diagBus
);

  microSeqPkg::tAdr dispVal;
  microSeqPkg::tAdr aread;
  microSeqPkg::tAdr loc;
  microSeqPkg::tAdr retAdr;
  microSeqPkg::tAdr diagAdrReg;
  microSeqPkg::tAdr skipVal;
  logic [microSeqPkg::stackPtrWidth-1:0] stackPtr;

  // Condition vector doubled so a triplet can wrap past bit 7
  logic [2*microSeqPkg::condInWidth-1:0] condWrap;
  logic [2:0] condSel;
  logic [2:0] condTriplet;
  logic isCond3;
  logic skipBit;
  logic push;
  logic pop;

  //////////////////////////////
  // Condition decode
  //////////////////////////////

  assign condSel = cramWord.cond[2:0];
  assign condWrap = {condIn, condIn};
  assign isCond3 = (cramWord.disp == microSeqPkg::dispCond3);

  // Bit 8 takes condIn[condSel], bits 9 and 10 the next two up
  assign condTriplet = condWrap[condSel +: 3];

  // Under dispCond3 the cond field picks the triplet and no skip is taken
  assign skipBit = cramWord.cond[3] & ~isCond3 & condIn[condSel];
  assign skipVal = {{(microSeqPkg::adrWidth - 1){1'b0}}, skipBit};

  //////////////////////////////
  // Dispatch mux
  //////////////////////////////

  always_comb begin
    case (cramWord.disp)
      microSeqPkg::dispDiag:   dispVal = diagAdrReg;
      microSeqPkg::dispDramJ:  dispVal = dramJ;
      microSeqPkg::dispAread:  dispVal = aread;
      microSeqPkg::dispReturn: dispVal = retAdr;
      microSeqPkg::dispCond3: begin
        dispVal = {condTriplet, {(microSeqPkg::adrWidth - 3){1'b0}}};
      end
      default:                 dispVal = '0;
    endcase
  end

  // All sources OR together, the trap forces every bit to one
  assign cradr = cramWord.j | dispVal | skipVal | {microSeqPkg::adrWidth{force1777}};

  //////////////////////////////
  // AREAD and current location
  //////////////////////////////

  // loc tracks the address of the word now held in cramWord
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      aread <= '0;
      loc <= '0;
    end else if (run) begin
      aread <= (dramA == '0) ? dramJ : '0;
      loc <= cradr;
    end
  end

  //////////////////////////////
  // Subroutine stack
  //////////////////////////////

  // A trap saves the interrupted location like a call
  assign push = cramWord.call | force1777;
  assign pop = (cramWord.disp == microSeqPkg::dispReturn) & ~force1777;

  sbrStack i_sbrStack (
    .eboxClk  (eboxClk),
    .arstN    (arstN),
    .run      (run),
    .push     (push),
    .pop      (pop),
    .pushAdr  (loc),
    .retAdr   (retAdr),
    .stackPtr (stackPtr)
  );

  //////////////////////////////
  // Diagnostics
  //////////////////////////////

  craDiag i_craDiag (
    .eboxClk     (eboxClk),
    .arstN       (arstN),
    .diagLoadEn  (diagLoadEn),
    .diagLoadVal (diagLoadVal),
    .diagSel     (diagSel),
    .diagRead    (diagRead),
    .stackPtr    (stackPtr),
    .retAdr      (retAdr),
    .cradr       (cradr),
    .loc         (loc),
    .diagAdrReg  (diagAdrReg),
    .diagBus     (diagBus)
  );

endmodule

//--- verilog/craDiag.sv
`timescale 1ns/1ps

module craDiag (
  input  logic                                  eboxClk,
  input  logic                                  arstN,
  input  logic                                  diagLoadEn,
  input  microSeqPkg::tAdr                      diagLoadVal,
  input  microSeqPkg::tDiagSel                  diagSel,
  input  logic                                  diagRead,
  input  logic [microSeqPkg::stackPtrWidth-1:0] stackPtr,
  input  microSeqPkg::tAdr                      retAdr,
  input  microSeqPkg::tAdr                      cradr,
  input  microSeqPkg::tAdr                      loc,
  output microSeqPkg::tAdr                      diagAdrReg,
  output microSeqPkg::tDiagBus                  diagBus
);

  microSeqPkg::tAdr readVal;

  // Diagnostic dispatch address, loaded independent of run
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      diagAdrReg <= '0;
    end else if (diagLoadEn) begin
      diagAdrReg <= diagLoadVal;
    end
  end

  //////////////////////////////
  // Readback mux
  //////////////////////////////

  always_comb begin
    case (diagSel)
      microSeqPkg::diagStackPtr: begin
        readVal = {{(microSeqPkg::adrWidth - microSeqPkg::stackPtrWidth){1'b0}}, stackPtr};
      end
      microSeqPkg::diagRet:     readVal = retAdr;
      microSeqPkg::diagAdr:     readVal = cradr;
      microSeqPkg::diagLoc:     readVal = loc;
      microSeqPkg::diagDispAdr: readVal = diagAdrReg;
      default:                  readVal = '0;
    endcase
  end

  // Bus idles at zero when not read
  always_comb begin
    diagBus.valid = diagRead;
    diagBus.data = diagRead ? readVal : '0;
  end

endmodule

//--- verilog/microSeq.sv
`timescale 1ns/1ps

module microSeq (
  input  logic                                 eboxClk,
  input  logic                                 arstN,
  input  logic                                 run,
  input  logic                                 force1777,
  input  logic [microSeqPkg::dramAWidth-1:0]   dramA,
  input  microSeqPkg::tAdr                     dramJ,
  input  logic [microSeqPkg::condInWidth-1:0]  condIn,
  input  logic                                 loadEn,
  input  microSeqPkg::tAdr                     loadAdr,
  input  microSeqPkg::tCram                    loadWord,
  input  microSeqPkg::tDiagSel                 diagSel,
  input  logic                                 diagRead,
  input  logic                                 diagLoadEn,
  input  microSeqPkg::tAdr                     diagLoadVal,
  output microSeqPkg::tAdr                     cradr,
  output microSeqPkg::tDiagBus                 diagBus
);

  // Current microword from the control store
  microSeqPkg::tCram cramWord;

  microSeqCrm i_microSeqCrm (
    .eboxClk  (eboxClk),
    .arstN    (arstN),
    .run      (run),
    .cradr    (cradr),
    .loadEn   (loadEn),
    .loadAdr  (loadAdr),
    .loadWord (loadWord),
    .cramWord (cramWord)
  );

  // Next address forms combinationally and feeds back to the store
  cra i_cra (
    .eboxClk     (eboxClk),
    .arstN       (arstN),
    .run         (run),
    .force1777   (force1777),
    .cramWord    (cramWord),
    .dramA       (dramA),
    .dramJ       (dramJ),
    .condIn      (condIn),
    .diagSel     (diagSel),
    .diagRead    (diagRead),
    .diagLoadEn  (diagLoadEn),
    .diagLoadVal (diagLoadVal),
    .cradr       (cradr),
    .diagBus     (diagBus)
  );

endmodule

//--- verilog/microSeqCrm.sv
`timescale 1ns/1ps

module microSeqCrm (
  input  logic               eboxClk,
  input  logic               arstN,
  input  logic               run,
  input  microSeqPkg::tAdr   cradr,
  input  logic               loadEn,
  input  microSeqPkg::tAdr   loadAdr,
  input  microSeqPkg::tCram  loadWord,
  output microSeqPkg::tCram  cramWord
);

  // Control store array
  microSeqPkg::tCram mem [microSeqPkg::cramWords];

  //////////////////////////////
  // Load port
  //////////////////////////////

  // Writes are only taken while the sequencer is stopped
  always_ff @(posedge eboxClk) begin
    if (!run && loadEn) begin
      mem[loadAdr] <= loadWord;
    end
  end

  //////////////////////////////
  // Microword register
  //////////////////////////////

  // The word fetched here is the one executing in the following cycle
  // Zero after reset gives j of 0 with no dispatch, skip or call
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      cramWord <= '0;
    end else if (run) begin
      cramWord <= mem[cradr];
    end
  end

endmodule

//--- verilog/microSeqPkg.sv
package microSeqPkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////

  // Control store address width, 2K words
  localparam int adrWidth = 11;
  localparam int cramWords = 2 ** adrWidth;

  // Subroutine stack
  localparam int stackDepth = 16;
  localparam int stackIdxWidth = 4;
  localparam int stackPtrWidth = 2 * stackIdxWidth;

  // Pointer load state, high half 1111 and low half four steps behind it
  localparam logic [stackPtrWidth-1:0] stackPtrLoad = 8'hF5;

  // Datapath inputs seen by the sequencer
  localparam int condInWidth = 8;
  localparam int dramAWidth = 3;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [adrWidth-1:0] tAdr;

  // Dispatch field of the microword
  typedef enum logic [4:0] {
    dispNone   = 5'd0,
    dispDiag   = 5'd1,
    dispDramJ  = 5'd2,
    dispAread  = 5'd3,
    dispReturn = 5'd4,
    dispCond3  = 5'd5
  } tDisp;

  // Skip field, bit 3 enables the skip and bits 2..0 pick the condition
  typedef enum logic [3:0] {
    condNone = 4'h0,
    cond0    = 4'h8,
    cond1    = 4'h9,
    cond2    = 4'hA,
    cond3    = 4'hB,
    cond4    = 4'hC,
    cond5    = 4'hD,
    cond6    = 4'hE,
    cond7    = 4'hF
  } tCond;

  // One microword, 21 bits
  typedef struct packed {
    tAdr  j;
    tDisp disp;
    tCond cond;
    logic call;
  } tCram;

  // Diagnostic readback selection
  typedef enum logic [2:0] {
    diagStackPtr = 3'd0,
    diagRet      = 3'd1,
    diagAdr      = 3'd2,
    diagLoc      = 3'd3,
    diagDispAdr  = 3'd4
  } tDiagSel;

  typedef struct packed {
    logic valid;
    tAdr  data;
  } tDiagBus;

endpackage

//--- verilog/sbrStack.sv
`timescale 1ns/1ps

module sbrStack (
  input  logic                                   eboxClk,
  input  logic                                   arstN,
  input  logic                                   run,
  input  logic                                   push,
  input  logic                                   pop,
  input  microSeqPkg::tAdr                       pushAdr,
  output microSeqPkg::tAdr                       retAdr,
  output logic [microSeqPkg::stackPtrWidth-1:0]  stackPtr
);

  microSeqPkg::tAdr stack [microSeqPkg::stackDepth];

  // High half is the write slot, low half trails it by four steps
  logic [microSeqPkg::stackIdxWidth-1:0] ptrHi;
  logic [microSeqPkg::stackIdxWidth-1:0] ptrLo;
  logic [microSeqPkg::stackIdxWidth-1:0] rdIdx;
  logic fwdBit;
  logic backBit;
  logic doPush;
  logic doPop;

  assign doPush = run & push;
  assign doPop = run & pop;
  assign stackPtr = {ptrHi, ptrLo};

  //////////////////////////////
  // Pointer sequence
  //////////////////////////////

  // XOR feedback with the all-zero term added so the walk covers 16 states
  // Forward  1111 1110 1100 1000 0000 0001 0010 0100 ...
  assign fwdBit = ptrHi[0] ^ ptrHi[1] ^ (ptrHi[3:1] == 3'b000);

  // Bit lost from the low half on the last forward shift
  assign backBit = ptrLo[3] ^ ptrLo[0] ^ (ptrLo[2:0] == 3'b000);

  // Slot written by the last push, the previous high half
  assign rdIdx = {ptrHi[2:0], ptrLo[3]};

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      {ptrHi, ptrLo} <= microSeqPkg::stackPtrLoad;
    end else if (doPush && doPop) begin
      {ptrHi, ptrLo} <= microSeqPkg::stackPtrLoad;
    end else if (doPush) begin
      ptrHi <= {fwdBit, ptrHi[3:1]};
      ptrLo <= {ptrHi[0], ptrLo[3:1]};
    end else if (doPop) begin
      ptrHi <= {ptrHi[2:0], ptrLo[3]};
      ptrLo <= {ptrLo[2:0], backBit};
    end
  end

  //////////////////////////////
  // Stack storage
  //////////////////////////////

  // Return word refreshes only in a cycle with no stack traffic
  always_ff @(posedge eboxClk) begin
    if (doPush && !doPop) begin
      stack[ptrHi] <= pushAdr;
    end
    if (run && !push && !pop) begin
      retAdr <= stack[rdIdx];
    end
  end

endmodule
